// File: Makefile
TOP = vai_serve_tb

.PHONY: all compile run clean

all: run

compile:
	verilator --binary --timing -Wno-fatal -f list.f --top-module $(TOP) -Mdir obj_dir -o $(TOP)

run: compile
	./obj_dir/$(TOP) | tee sim.log
	grep -F -q "*** TEST PASSED ***" sim.log

clean:
	rm -rf obj_dir sim.log

// File: list.f
+incdir+rtl
rtl/vai_host_pkg.sv
rtl/vai_ctl_pkg.sv
rtl/vai_serve_rx.sv
rtl/vai_serve_tx.sv
rtl/vai_credit_mgr.sv
rtl/vai_serve_top.sv
tb/vai_serve_tb.sv

// File: rtl/vai_config.svh
`ifndef VAI_CONFIG_SVH
`define VAI_CONFIG_SVH

// Sub-units sharing the host link
`define VAI_NUM_SUB_AFUS 4
`define VAI_VMID_WIDTH 2

// Outstanding requests per unit, also the depth of each request queue
`define VAI_UNIT_CREDITS 4
`define VAI_HOST_CREDIT_MAX 16

// Each MMIO region spans 64 words
`define VAI_MMIO_REGION_BITS 6

`endif

// File: rtl/vai_credit_mgr.sv
`timescale 1ns/10ps
`include "vai_config.svh"

module vai_credit_mgr
    import vai_ctl_pkg::*;
(
    input  logic                              clk,
    input  logic                              reset,
    input  logic                              up_credit,
    input  logic                              tx_issue,
    input  logic [1:0]                        rsp_done_valid,
    input  logic [2*`VAI_VMID_WIDTH-1:0]      rsp_done_vmid,
    output logic [`VAI_NUM_SUB_AFUS-1:0]      afu_credit,
    output logic                              host_credit_avail
);

    localparam int N = `VAI_NUM_SUB_AFUS;
    localparam int VW = `VAI_VMID_WIDTH;
    localparam int D = `VAI_UNIT_CREDITS;
    localparam int HMAX = `VAI_HOST_CREDIT_MAX;

    mgr_state_t   state;
    credit_cnt_t  fill_cnt;
    credit_cnt_t  host_cnt;
    credit_cnt_t  hold_cnt [N];  // Returns that could not go out yet
    vmid_t        rd_vmid;
    vmid_t        wr_vmid;
    logic [N-1:0] ret_rd;
    logic [N-1:0] ret_wr;

    assign rd_vmid = rsp_done_vmid[VW-1:0];
    assign wr_vmid = rsp_done_vmid[2*VW-1:VW];
    assign host_credit_avail = (host_cnt != '0);

    always_comb
    begin
        for (int v = 0; v < N; v++)
        begin
            ret_rd[v] = rsp_done_valid[0] && (rd_vmid == vmid_t'(v));
            ret_wr[v] = rsp_done_valid[1] && (wr_vmid == vmid_t'(v));
        end
    end

    always_ff @(posedge clk)
    begin
        if (reset)
        begin
            state <= IDLE;
            fill_cnt <= '0;
            afu_credit <= '0;
            for (int v = 0; v < N; v++)
            begin
                hold_cnt[v] <= '0;
            end
        end
        else
        begin
            case (state)
                IDLE:
                begin
                    state <= FILL;
                end
                FILL:
                begin
                    afu_credit <= '1;  // Every unit gets its whole allowance
                    fill_cnt <= fill_cnt + 1'b1;
                    if (fill_cnt == credit_cnt_t'(D-1))
                    begin
                        state <= RUN;
                    end
                end
                RUN:
                begin
                    for (int v = 0; v < N; v++)
                    begin
                        afu_credit[v] <= ret_rd[v] || ret_wr[v] || (hold_cnt[v] != '0);
                        hold_cnt[v] <= hold_cnt[v] + ret_rd[v] + ret_wr[v] -
                                       (ret_rd[v] || ret_wr[v] || (hold_cnt[v] != '0));
                    end
                end
                default:
                begin
                    state <= IDLE;
                end
            endcase
        end
    end

    // Saturates at the ceiling, never underflows since tx needs a credit to issue
    always_ff @(posedge clk)
    begin
        if (reset)
        begin
            host_cnt <= '0;
        end
        else if (up_credit && !tx_issue && (host_cnt != credit_cnt_t'(HMAX)))
        begin
            host_cnt <= host_cnt + 1'b1;
        end
        else if (tx_issue && !up_credit)
        begin
            host_cnt <= host_cnt - 1'b1;
        end
    end

endmodule

// File: rtl/vai_ctl_pkg.sv
package vai_ctl_pkg;

`include "vai_config.svh"

    // Index of a sub-unit, carried in the top metadata bits
    typedef logic [`VAI_VMID_WIDTH-1:0] vmid_t;

    // Must hold VAI_HOST_CREDIT_MAX itself
    typedef logic [$clog2(`VAI_HOST_CREDIT_MAX+1)-1:0] credit_cnt_t;

    typedef enum logic [1:0]
    {
        IDLE,
        FILL,
        RUN
    } mgr_state_t;

endpackage

// File: rtl/vai_host_pkg.sv
package vai_host_pkg;

    // Host memory byte address
    typedef logic [31:0] host_addr_t;

    // Request metadata, echoed back by the host in the response
    typedef logic [15:0] mdata_t;

    // One data word on any channel
    typedef logic [63:0] host_data_t;

    // MMIO word address
    typedef logic [15:0] mmio_addr_t;

endpackage

// File: rtl/vai_serve_rx.sv
`timescale 1ns/10ps
`include "vai_config.svh"

module vai_serve_rx
    import vai_host_pkg::*;
    import vai_ctl_pkg::*;
(
    input  logic                                              clk,
    input  logic                                              reset,
    input  logic                                              up_rd_rsp_valid,
    input  mdata_t                                            up_rd_rsp_mdata,
    input  host_data_t                                        up_rd_rsp_data,
    input  logic                                              up_wr_rsp_valid,
    input  mdata_t                                            up_wr_rsp_mdata,
    input  logic                                              up_mmio_wr_valid,
    input  mmio_addr_t                                        up_mmio_addr,
    input  host_data_t                                        up_mmio_data,
    output logic [`VAI_NUM_SUB_AFUS-1:0]                      afu_rd_rsp_valid,
    output mdata_t                                            afu_rd_rsp_mdata,
    output host_data_t                                        afu_rd_rsp_data,
    output logic [`VAI_NUM_SUB_AFUS-1:0]                      afu_wr_rsp_valid,
    output mdata_t                                            afu_wr_rsp_mdata,
    output logic [`VAI_NUM_SUB_AFUS-1:0]                      afu_mmio_wr_valid,
    output mmio_addr_t                                        afu_mmio_addr,
    output host_data_t                                        afu_mmio_data,
    output logic [`VAI_NUM_SUB_AFUS*$bits(host_addr_t)-1:0]   offset_table,
    output logic [1:0]                                        rsp_done_valid,
    output logic [2*`VAI_VMID_WIDTH-1:0]                      rsp_done_vmid
);

    localparam int N = `VAI_NUM_SUB_AFUS;
    localparam int VW = `VAI_VMID_WIDTH;
    localparam int RB = `VAI_MMIO_REGION_BITS;
    localparam int MW = $bits(mdata_t);
    localparam int AW = $bits(mmio_addr_t);

    logic             t1_rd_valid;
    logic             t1_wr_valid;
    logic             t1_mmio_valid;
    mdata_t           t1_rd_mdata;
    mdata_t           t1_wr_mdata;
    host_data_t       t1_rd_data;
    host_data_t       t1_mmio_data;
    mmio_addr_t       t1_mmio_addr;
    logic [AW-RB-1:0] t1_region;

    logic             t2_rd_valid;
    logic             t2_wr_valid;
    logic             t2_mmio_fwd;
    logic             t2_ctl_wr;
    mdata_t           t2_rd_mdata;
    mdata_t           t2_wr_mdata;
    host_data_t       t2_rd_data;
    host_data_t       t2_mmio_data;
    logic [RB-1:0]    t2_mmio_low;
    vmid_t            t2_rd_vmid;
    vmid_t            t2_wr_vmid;
    vmid_t            t2_mmio_vmid;

    logic [N-1:0]     rd_sel;
    logic [N-1:0]     wr_sel;
    logic [N-1:0]     mmio_sel;

    host_addr_t [N-1:0] offset_mem;

    assign t1_region = t1_mmio_addr[AW-1:RB];
    assign offset_table = offset_mem;

    always_ff @(posedge clk)
    begin
        if (reset)
        begin
            t1_rd_valid <= 1'b0;
            t1_wr_valid <= 1'b0;
            t1_mmio_valid <= 1'b0;
        end
        else
        begin
            t1_rd_valid <= up_rd_rsp_valid;
            t1_wr_valid <= up_wr_rsp_valid;
            t1_mmio_valid <= up_mmio_wr_valid;
        end
        t1_rd_mdata <= up_rd_rsp_mdata;
        t1_rd_data <= up_rd_rsp_data;
        t1_wr_mdata <= up_wr_rsp_mdata;
        t1_mmio_addr <= up_mmio_addr;
        t1_mmio_data <= up_mmio_data;
    end

    always_ff @(posedge clk)
    begin
        if (reset)
        begin
            t2_rd_valid <= 1'b0;
            t2_wr_valid <= 1'b0;
            t2_mmio_fwd <= 1'b0;
            t2_ctl_wr <= 1'b0;
        end
        else
        begin
            t2_rd_valid <= t1_rd_valid;
            t2_wr_valid <= t1_wr_valid;
            // Regions past the last unit go nowhere
            t2_mmio_fwd <= t1_mmio_valid && (t1_region != '0) && (t1_region <= N);
            t2_ctl_wr <= t1_mmio_valid && (t1_region == '0);
        end
        t2_rd_vmid <= t1_rd_mdata[MW-1 -: VW];
        t2_wr_vmid <= t1_wr_mdata[MW-1 -: VW];
        t2_mmio_vmid <= vmid_t'(t1_region - 1'b1);
        t2_rd_mdata <= t1_rd_mdata;
        t2_rd_data <= t1_rd_data;
        t2_wr_mdata <= t1_wr_mdata;
        t2_mmio_low <= t1_mmio_addr[RB-1:0];
        t2_mmio_data <= t1_mmio_data;
    end

    always_comb
    begin
        for (int v = 0; v < N; v++)
        begin
            rd_sel[v] = t2_rd_valid && (t2_rd_vmid == vmid_t'(v));
            wr_sel[v] = t2_wr_valid && (t2_wr_vmid == vmid_t'(v));
            mmio_sel[v] = t2_mmio_fwd && (t2_mmio_vmid == vmid_t'(v));
        end
    end

    always_ff @(posedge clk)
    begin
        if (reset)
        begin
            afu_rd_rsp_valid <= '0;
            afu_wr_rsp_valid <= '0;
            afu_mmio_wr_valid <= '0;
            rsp_done_valid <= '0;
            offset_mem <= '0;
        end
        else
        begin
            afu_rd_rsp_valid <= rd_sel;
            afu_wr_rsp_valid <= wr_sel;
            afu_mmio_wr_valid <= mmio_sel;
            rsp_done_valid <= {t2_wr_valid, t2_rd_valid};  // Bit 0 is the read channel
            if (t2_ctl_wr)
            begin
                offset_mem[t2_mmio_low[VW-1:0]] <= host_addr_t'(t2_mmio_data);
            end
        end
        afu_rd_rsp_mdata <= {{VW{1'b0}}, t2_rd_mdata[MW-VW-1:0]};
        afu_rd_rsp_data <= t2_rd_data;
        afu_wr_rsp_mdata <= {{VW{1'b0}}, t2_wr_mdata[MW-VW-1:0]};
        afu_mmio_addr <= mmio_addr_t'(t2_mmio_low);
        afu_mmio_data <= t2_mmio_data;
        rsp_done_vmid <= {t2_wr_vmid, t2_rd_vmid};
    end

endmodule

// File: rtl/vai_serve_top.sv
`timescale 1ns/10ps
`include "vai_config.svh"

module vai_serve_top
    import vai_host_pkg::*;
(
    input  logic                                              clk,
    input  logic                                              reset,
    input  logic [`VAI_NUM_SUB_AFUS-1:0]                      afu_req_valid,
    input  logic [`VAI_NUM_SUB_AFUS-1:0]                      afu_req_write,
    input  logic [`VAI_NUM_SUB_AFUS*$bits(host_addr_t)-1:0]   afu_req_addr,
    input  logic [`VAI_NUM_SUB_AFUS*$bits(mdata_t)-1:0]       afu_req_mdata,
    input  logic [`VAI_NUM_SUB_AFUS*$bits(host_data_t)-1:0]   afu_req_data,
    output logic [`VAI_NUM_SUB_AFUS-1:0]                      afu_credit,
    output logic [`VAI_NUM_SUB_AFUS-1:0]                      afu_rd_rsp_valid,
    output mdata_t                                            afu_rd_rsp_mdata,
    output host_data_t                                        afu_rd_rsp_data,
    output logic [`VAI_NUM_SUB_AFUS-1:0]                      afu_wr_rsp_valid,
    output mdata_t                                            afu_wr_rsp_mdata,
    output logic [`VAI_NUM_SUB_AFUS-1:0]                      afu_mmio_wr_valid,
    output mmio_addr_t                                        afu_mmio_addr,
    output host_data_t                                        afu_mmio_data,
    output logic                                              up_tx_valid,
    output logic                                              up_tx_write,
    output host_addr_t                                        up_tx_addr,
    output mdata_t                                            up_tx_mdata,
    output host_data_t                                        up_tx_data,
    input  logic                                              up_credit,
    input  logic                                              up_rd_rsp_valid,
    input  mdata_t                                            up_rd_rsp_mdata,
    input  host_data_t                                        up_rd_rsp_data,
    input  logic                                              up_wr_rsp_valid,
    input  mdata_t                                            up_wr_rsp_mdata,
    input  logic                                              up_mmio_wr_valid,
    input  mmio_addr_t                                        up_mmio_addr,
    input  host_data_t                                        up_mmio_data
);

    logic [`VAI_NUM_SUB_AFUS*$bits(host_addr_t)-1:0] offset_table;
    logic [1:0]                                      rsp_done_valid;
    logic [2*`VAI_VMID_WIDTH-1:0]                    rsp_done_vmid;
    logic                                            host_credit_avail;
    logic                                            tx_issue;

    vai_serve_rx u_rx (
        .clk               (clk),
        .reset             (reset),
        .up_rd_rsp_valid   (up_rd_rsp_valid),
        .up_rd_rsp_mdata   (up_rd_rsp_mdata),
        .up_rd_rsp_data    (up_rd_rsp_data),
        .up_wr_rsp_valid   (up_wr_rsp_valid),
        .up_wr_rsp_mdata   (up_wr_rsp_mdata),
        .up_mmio_wr_valid  (up_mmio_wr_valid),
        .up_mmio_addr      (up_mmio_addr),
        .up_mmio_data      (up_mmio_data),
        .afu_rd_rsp_valid  (afu_rd_rsp_valid),
        .afu_rd_rsp_mdata  (afu_rd_rsp_mdata),
        .afu_rd_rsp_data   (afu_rd_rsp_data),
        .afu_wr_rsp_valid  (afu_wr_rsp_valid),
        .afu_wr_rsp_mdata  (afu_wr_rsp_mdata),
        .afu_mmio_wr_valid (afu_mmio_wr_valid),
        .afu_mmio_addr     (afu_mmio_addr),
        .afu_mmio_data     (afu_mmio_data),
        .offset_table      (offset_table),
        .rsp_done_valid    (rsp_done_valid),
        .rsp_done_vmid     (rsp_done_vmid)
    );

    vai_serve_tx u_tx (
        .clk               (clk),
        .reset             (reset),
        .afu_req_valid     (afu_req_valid),
        .afu_req_write     (afu_req_write),
        .afu_req_addr      (afu_req_addr),
        .afu_req_mdata     (afu_req_mdata),
        .afu_req_data      (afu_req_data),
        .offset_table      (offset_table),
        .host_credit_avail (host_credit_avail),
        .up_tx_valid       (up_tx_valid),
        .up_tx_write       (up_tx_write),
        .up_tx_addr        (up_tx_addr),
        .up_tx_mdata       (up_tx_mdata),
        .up_tx_data        (up_tx_data),
        .tx_issue          (tx_issue)
    );

    vai_credit_mgr u_credit_mgr (
        .clk               (clk),
        .reset             (reset),
        .up_credit         (up_credit),
        .tx_issue          (tx_issue),
        .rsp_done_valid    (rsp_done_valid),
        .rsp_done_vmid     (rsp_done_vmid),
        .afu_credit        (afu_credit),
        .host_credit_avail (host_credit_avail)
    );

endmodule

// File: rtl/vai_serve_tx.sv
`timescale 1ns/10ps
`include "vai_config.svh"

module vai_serve_tx
    import vai_host_pkg::*;
    import vai_ctl_pkg::*;
(
    input  logic                                              clk,
    input  logic                                              reset,
    input  logic [`VAI_NUM_SUB_AFUS-1:0]                      afu_req_valid,
    input  logic [`VAI_NUM_SUB_AFUS-1:0]                      afu_req_write,
    input  logic [`VAI_NUM_SUB_AFUS*$bits(host_addr_t)-1:0]   afu_req_addr,
    input  logic [`VAI_NUM_SUB_AFUS*$bits(mdata_t)-1:0]       afu_req_mdata,
    input  logic [`VAI_NUM_SUB_AFUS*$bits(host_data_t)-1:0]   afu_req_data,
    input  logic [`VAI_NUM_SUB_AFUS*$bits(host_addr_t)-1:0]   offset_table,
    input  logic                                              host_credit_avail,
    output logic                                              up_tx_valid,
    output logic                                              up_tx_write,
    output host_addr_t                                        up_tx_addr,
    output mdata_t                                            up_tx_mdata,
    output host_data_t                                        up_tx_data,
    output logic                                              tx_issue
);

    localparam int N = `VAI_NUM_SUB_AFUS;
    localparam int VW = `VAI_VMID_WIDTH;
    localparam int D = `VAI_UNIT_CREDITS;
    localparam int PW = $clog2(D);
    localparam int HW = $bits(host_addr_t);
    localparam int MW = $bits(mdata_t);
    localparam int DW = $bits(host_data_t);

    logic       q_write [N][D];
    host_addr_t q_addr [N][D];
    mdata_t     q_mdata [N][D];
    host_data_t q_data [N][D];

    logic [PW-1:0] wr_ptr [N];
    logic [PW-1:0] rd_ptr [N];
    logic [PW:0]   q_count [N];
    logic [N-1:0]  q_pop;

    vmid_t rr_ptr;  // Unit granted last
    vmid_t grant_vmid;
    logic  grant_valid;

    assign tx_issue = grant_valid;

    // Search starts one past the last winner
    always_comb
    begin
        vmid_t idx;
        grant_valid = 1'b0;
        grant_vmid = rr_ptr;
        for (int i = 1; i <= N; i++)
        begin
            idx = vmid_t'(rr_ptr + i);
            if (!grant_valid && host_credit_avail && (q_count[idx] != '0))
            begin
                grant_valid = 1'b1;
                grant_vmid = idx;
            end
        end
        for (int u = 0; u < N; u++)
        begin
            q_pop[u] = grant_valid && (grant_vmid == vmid_t'(u));
        end
    end

    always_ff @(posedge clk)
    begin
        if (reset)
        begin
            rr_ptr <= '1;
            up_tx_valid <= 1'b0;
            for (int u = 0; u < N; u++)
            begin
                wr_ptr[u] <= '0;
                rd_ptr[u] <= '0;
                q_count[u] <= '0;
            end
        end
        else
        begin
            up_tx_valid <= grant_valid;
            if (grant_valid)
            begin
                rr_ptr <= grant_vmid;
            end
            for (int u = 0; u < N; u++)
            begin
                if (afu_req_valid[u])
                begin
                    wr_ptr[u] <= wr_ptr[u] + 1'b1;
                end
                if (q_pop[u])
                begin
                    rd_ptr[u] <= rd_ptr[u] + 1'b1;
                end
                q_count[u] <= q_count[u] + afu_req_valid[u] - q_pop[u];
            end
        end
    end

    always_ff @(posedge clk)
    begin
        for (int u = 0; u < N; u++)
        begin
            if (afu_req_valid[u])
            begin
                q_write[u][wr_ptr[u]] <= afu_req_write[u];
                q_addr[u][wr_ptr[u]] <= afu_req_addr[u*HW +: HW];
                q_mdata[u][wr_ptr[u]] <= afu_req_mdata[u*MW +: MW];
                q_data[u][wr_ptr[u]] <= afu_req_data[u*DW +: DW];
            end
        end
        if (grant_valid)
        begin
            up_tx_write <= q_write[grant_vmid][rd_ptr[grant_vmid]];
            up_tx_addr <= q_addr[grant_vmid][rd_ptr[grant_vmid]] +
                          offset_table[grant_vmid*HW +: HW];
            // Tag with the vmid so the response finds its way back
            up_tx_mdata <= {grant_vmid, q_mdata[grant_vmid][rd_ptr[grant_vmid]][MW-VW-1:0]};
            up_tx_data <= q_data[grant_vmid][rd_ptr[grant_vmid]];
        end
    end

endmodule

// File: tb/vai_serve_tb.sv
`timescale 1ns/10ps
`include "vai_config.svh"

module vai_serve_tb
    import vai_host_pkg::*;
    import vai_ctl_pkg::*;
();

    localparam int N = `VAI_NUM_SUB_AFUS;
    localparam int VW = `VAI_VMID_WIDTH;
    localparam int D = `VAI_UNIT_CREDITS;
    localparam int HMAX = `VAI_HOST_CREDIT_MAX;
    localparam int RB = `VAI_MMIO_REGION_BITS;
    localparam int HW = $bits(host_addr_t);
    localparam int MW = $bits(mdata_t);
    localparam int DW = $bits(host_data_t);

    logic              clk;
    logic              reset;
    logic [N-1:0]      afu_req_valid;
    logic [N-1:0]      afu_req_write;
    logic [N*HW-1:0]   afu_req_addr;
    logic [N*MW-1:0]   afu_req_mdata;
    logic [N*DW-1:0]   afu_req_data;
    logic [N-1:0]      afu_credit;
    logic [N-1:0]      afu_rd_rsp_valid;
    mdata_t            afu_rd_rsp_mdata;
    host_data_t        afu_rd_rsp_data;
    logic [N-1:0]      afu_wr_rsp_valid;
    mdata_t            afu_wr_rsp_mdata;
    logic [N-1:0]      afu_mmio_wr_valid;
    mmio_addr_t        afu_mmio_addr;
    host_data_t        afu_mmio_data;
    logic              up_tx_valid;
    logic              up_tx_write;
    host_addr_t        up_tx_addr;
    mdata_t            up_tx_mdata;
    host_data_t        up_tx_data;
    logic              up_credit;
    logic              up_rd_rsp_valid;
    mdata_t            up_rd_rsp_mdata;
    host_data_t        up_rd_rsp_data;
    logic              up_wr_rsp_valid;
    mdata_t            up_wr_rsp_mdata;
    logic              up_mmio_wr_valid;
    mmio_addr_t        up_mmio_addr;
    host_data_t        up_mmio_data;

    int         cyc;
    bit         throttle;
    int         host_ledger;  // Credits granted to the DUT and not yet used
    host_addr_t offset_model [N];
    int         unit_cred [N];
    int         outstanding [N];
    int         ret_pending [N];  // Deliveries whose credit has not come back yet

    // Requests sent by the units, oldest first
    int         req_unit [$];
    logic       req_write [$];
    host_addr_t req_addr [$];
    mdata_t     req_mdata [$];
    host_data_t req_data [$];

    logic       h_write [$];
    mdata_t     h_mdata [$];
    int         h_due [$];

    // Expected unit side outputs, a ring indexed by cycle
    logic [N-1:0] exp_rd_valid [8];
    mdata_t       exp_rd_mdata [8];
    host_data_t   exp_rd_data [8];
    logic [N-1:0] exp_wr_valid [8];
    mdata_t       exp_wr_mdata [8];
    logic [N-1:0] exp_mmio_valid [8];
    mmio_addr_t   exp_mmio_addr [8];
    host_data_t   exp_mmio_data [8];

    vai_serve_top DUT (.*);

    always #5 clk = ~clk;

    task automatic stop_with_failure(input string why);
        $display("%s", why);
        $display("*** TEST FAILED ***");
        $fatal(1, "Simulation stopped on the first failure");
    endtask

    task automatic check_value(input string name, input logic [63:0] expected,
                               input logic [63:0] actual);
        if (expected !== actual)
        begin
            stop_with_failure($sformatf("Error: %s expected %0h actual %0h",
                                        name, expected, actual));
        end
    endtask

    task automatic check_credits();
        for (int u = 0; u < N; u++)
        begin
            check_value("afu_credit", ret_pending[u] != 0, afu_credit[u]);
            if (afu_credit[u])
            begin
                ret_pending[u]--;
                unit_cred[u]++;
            end
        end
    endtask

    task automatic check_deliveries(input int slot);
        int done;
        check_value("afu_rd_rsp_valid", exp_rd_valid[slot], afu_rd_rsp_valid);
        if (afu_rd_rsp_valid != '0)
        begin
            check_value("afu_rd_rsp_mdata", exp_rd_mdata[slot], afu_rd_rsp_mdata);
            check_value("afu_rd_rsp_data", exp_rd_data[slot], afu_rd_rsp_data);
        end
        check_value("afu_wr_rsp_valid", exp_wr_valid[slot], afu_wr_rsp_valid);
        if (afu_wr_rsp_valid != '0)
        begin
            check_value("afu_wr_rsp_mdata", exp_wr_mdata[slot], afu_wr_rsp_mdata);
        end
        check_value("afu_mmio_wr_valid", exp_mmio_valid[slot], afu_mmio_wr_valid);
        if (afu_mmio_wr_valid != '0)
        begin
            check_value("afu_mmio_addr", exp_mmio_addr[slot], afu_mmio_addr);
            check_value("afu_mmio_data", exp_mmio_data[slot], afu_mmio_data);
        end
        for (int u = 0; u < N; u++)
        begin
            done = int'(afu_rd_rsp_valid[u]) + int'(afu_wr_rsp_valid[u]);
            outstanding[u] -= done;
            ret_pending[u] += done;
        end
        exp_rd_valid[slot] = '0;
        exp_wr_valid[slot] = '0;
        exp_mmio_valid[slot] = '0;
    endtask

    task automatic check_issue();
        logic [N-1:0] head_seen;
        int           k;
        int           issuer;
        host_addr_t   exp_addr;
        if (up_tx_valid)
        begin
            if (host_ledger == 0)
            begin
                stop_with_failure("A host request was issued without a host credit");
            end
            host_ledger--;
            head_seen = '0;
            k = -1;
            for (int j = 0; j < req_unit.size(); j++)
            begin
                if (!head_seen[req_unit[j]])  // A request leaves only from the head of its queue
                begin
                    head_seen[req_unit[j]] = 1'b1;
                    if (k < 0 && req_data[j] === up_tx_data)
                    begin
                        k = j;
                    end
                end
            end
            if (k < 0)
            begin
                stop_with_failure("A host request matches the oldest request of no unit");
            end
            issuer = req_unit[k];
            exp_addr = req_addr[k] + offset_model[issuer];
            check_value("up_tx_write", req_write[k], up_tx_write);
            check_value("up_tx_addr", exp_addr, up_tx_addr);
            check_value("up_tx_mdata", {vmid_t'(issuer), req_mdata[k][MW-VW-1:0]},
                        up_tx_mdata);
            check_value("up_tx_data", req_data[k], up_tx_data);
            h_write.push_back(up_tx_write);
            h_mdata.push_back(up_tx_mdata);
            h_due.push_back(cyc + 1 + int'($urandom % 6));
            req_unit.delete(k);
            req_write.delete(k);
            req_addr.delete(k);
            req_mdata.delete(k);
            req_data.delete(k);
        end
    endtask

    task automatic drop_host_entry(input int k);
        if (k >= 0)
        begin
            h_write.delete(k);
            h_mdata.delete(k);
            h_due.delete(k);
        end
    endtask

    task automatic drive_host(input int due_slot);
        int    rd_k;
        int    wr_k;
        vmid_t v;
        up_credit = 1'b0;
        up_rd_rsp_valid = 1'b0;
        up_wr_rsp_valid = 1'b0;
        if ($urandom % 64 == 0)
        begin
            throttle = !throttle;  // Back-pressure comes in bursts
        end
        if (host_ledger < HMAX && (throttle ? ($urandom % 8 == 0) : ($urandom % 4 != 0)))
        begin
            up_credit = 1'b1;
            host_ledger++;
        end
        rd_k = -1;
        wr_k = -1;
        for (int k = 0; k < h_due.size(); k++)
        begin
            if (h_due[k] <= cyc && !h_write[k] && rd_k < 0)
            begin
                rd_k = k;
            end
            if (h_due[k] <= cyc && h_write[k] && wr_k < 0)
            begin
                wr_k = k;
            end
        end
        if (rd_k >= 0)
        begin
            up_rd_rsp_valid = 1'b1;
            up_rd_rsp_mdata = h_mdata[rd_k];
            up_rd_rsp_data = {$urandom, $urandom};
            v = h_mdata[rd_k][MW-1 -: VW];
            exp_rd_valid[due_slot][v] = 1'b1;
            exp_rd_mdata[due_slot] = {{VW{1'b0}}, h_mdata[rd_k][MW-VW-1:0]};
            exp_rd_data[due_slot] = up_rd_rsp_data;
        end
        if (wr_k >= 0)
        begin
            up_wr_rsp_valid = 1'b1;
            up_wr_rsp_mdata = h_mdata[wr_k];
            v = h_mdata[wr_k][MW-1 -: VW];
            exp_wr_valid[due_slot][v] = 1'b1;
            exp_wr_mdata[due_slot] = {{VW{1'b0}}, h_mdata[wr_k][MW-VW-1:0]};
        end
        // Higher index first so the other one stays valid
        if (rd_k > wr_k)
        begin
            drop_host_entry(rd_k);
            drop_host_entry(wr_k);
        end
        else
        begin
            drop_host_entry(wr_k);
            drop_host_entry(rd_k);
        end
    endtask

    task automatic drive_mmio(input bit mmio_on, input int due_slot);
        int            region;
        logic [RB-1:0] low;
        host_data_t    data;
        up_mmio_wr_valid = 1'b0;
        if (mmio_on && $urandom % 2 == 0)
        begin
            region = ($urandom % 3 == 0) ? 0 : 1 + int'($urandom % (N + 2));
            low = RB'($urandom);
            data = {$urandom, $urandom};
            up_mmio_wr_valid = 1'b1;
            up_mmio_addr = mmio_addr_t'((region << RB) | int'(low));
            up_mmio_data = data;
            if (region == 0)
            begin
                offset_model[low[VW-1:0]] = data[HW-1:0];
            end
            else if (region <= N)
            begin
                exp_mmio_valid[due_slot][region-1] = 1'b1;
                exp_mmio_addr[due_slot] = mmio_addr_t'(low);
                exp_mmio_data[due_slot] = data;
            end
        end
    endtask

    task automatic drive_units(input bit req_on);
        afu_req_valid = '0;
        for (int u = 0; u < N; u++)
        begin
            if (req_on && unit_cred[u] > 0 && $urandom % 3 == 0)
            begin
                afu_req_valid[u] = 1'b1;
                afu_req_write[u] = $urandom % 2;
                afu_req_addr[u*HW +: HW] = $urandom;
                afu_req_mdata[u*MW +: MW] = mdata_t'($urandom);
                afu_req_data[u*DW +: DW] = {$urandom, $urandom};
                unit_cred[u]--;
                outstanding[u]++;
                req_unit.push_back(u);
                req_write.push_back(afu_req_write[u]);
                req_addr.push_back(afu_req_addr[u*HW +: HW]);
                req_mdata.push_back(afu_req_mdata[u*MW +: MW]);
                req_data.push_back(afu_req_data[u*DW +: DW]);
            end
        end
    endtask

    // Outputs are sampled 1 ns after the edge, then the next inputs are driven
    task automatic run_cycle(input bit mmio_on, input bit req_on);
        @(posedge clk);
        #1;
        cyc++;
        check_credits();
        check_deliveries(cyc % 8);
        check_issue();
        drive_host((cyc + 3) % 8);
        drive_mmio(mmio_on, (cyc + 3) % 8);
        drive_units(req_on);
    endtask

    function automatic bit traffic_idle();
        bit idle;
        idle = (req_unit.size() == 0) && (h_due.size() == 0);
        for (int u = 0; u < N; u++)
        begin
            idle = idle && (outstanding[u] == 0) && (ret_pending[u] == 0);
        end
        return idle;
    endfunction

    task automatic drain_traffic();
        int waited;
        waited = 0;
        while (!traffic_idle())
        begin
            run_cycle(1'b0, 1'b0);
            waited++;
            if (waited > 500)
            begin
                stop_with_failure("Timeout waiting for outstanding requests to drain");
            end
        end
    endtask

    initial
    begin
        int seed_value;
        int waited;
        bit fill_done;
        int fill_seen [N];
        seed_value = $urandom(32'hf3fc);
        clk = 1'b0;
        reset = 1'b1;
        afu_req_valid = '0;
        afu_req_write = '0;
        afu_req_addr = '0;
        afu_req_mdata = '0;
        afu_req_data = '0;
        up_credit = 1'b0;
        up_rd_rsp_valid = 1'b0;
        up_rd_rsp_mdata = '0;
        up_rd_rsp_data = '0;
        up_wr_rsp_valid = 1'b0;
        up_wr_rsp_mdata = '0;
        up_mmio_wr_valid = 1'b0;
        up_mmio_addr = '0;
        up_mmio_data = '0;
        cyc = 0;
        throttle = 1'b0;
        host_ledger = 0;
        for (int s = 0; s < 8; s++)
        begin
            exp_rd_valid[s] = '0;
            exp_wr_valid[s] = '0;
            exp_mmio_valid[s] = '0;
        end
        for (int u = 0; u < N; u++)
        begin
            offset_model[u] = '0;
            unit_cred[u] = 0;
            outstanding[u] = 0;
            ret_pending[u] = 0;
            fill_seen[u] = 0;
        end

        repeat (3) @(posedge clk);
        #1;
        check_value("reset afu_credit", 0, afu_credit);
        check_value("reset afu_rd_rsp_valid", 0, afu_rd_rsp_valid);
        check_value("reset afu_wr_rsp_valid", 0, afu_wr_rsp_valid);
        check_value("reset afu_mmio_wr_valid", 0, afu_mmio_wr_valid);
        check_value("reset up_tx_valid", 0, up_tx_valid);
        reset = 1'b0;

        // Every unit gets its whole allowance in back to back pulses
        fill_done = 1'b0;
        waited = 0;
        while (!fill_done)
        begin
            @(posedge clk);
            #1;
            cyc++;
            waited++;
            if (waited > 20)
            begin
                stop_with_failure("Timeout waiting for the initial credit fill");
            end
            if (afu_credit != '0)
            begin
                check_value("fill afu_credit", {N{1'b1}}, afu_credit);
                for (int u = 0; u < N; u++)
                begin
                    fill_seen[u]++;
                end
            end
            else if (fill_seen[0] != 0)
            begin
                fill_done = 1'b1;
            end
        end
        for (int u = 0; u < N; u++)
        begin
            check_value("fill credit count", D, fill_seen[u]);
            unit_cred[u] = D;
        end

        for (int round = 0; round < 2; round++)
        begin
            repeat (40) run_cycle(1'b1, 1'b0);
            repeat (4) run_cycle(1'b0, 1'b0);  // Last control write lands in the table
            repeat (400) run_cycle(1'b0, 1'b1);
            drain_traffic();
        end

        $display("*** TEST PASSED ***");
        $finish;
    end

endmodule
